// ==== vdp_upscan.f ====
hw/vdp_pkg.sv
hw/vdp_linebuf.sv
hw/vdp_doublebuf.sv
hw/vdp_upscan_timing.sv
hw/vdp_scan_cfg.sv
hw/vdp_pixel_out.sv
hw/vdp_upscan_top.sv
test/vdp_upscan_props.sv
test/tb_vdp_upscan.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := tb_vdp_upscan
FILELIST := vdp_upscan.f
OBJ_DIR  := obj_dir
LOG      := sim.log

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_vdp_upscan.sv ====
// Directed testbench for the upscan converter, source lines in and doubled lines out
module tb_vdp_upscan
    import vdp_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Cycles to wait for out_de before giving up
    localparam int WAIT_LIMIT = 2000;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  src_hs;
    logic                  src_we;
    logic [X_W-1:0]        src_x;
    rgb_t                  src_pixel;
    logic                  cfg_we;
    cfg_addr_e             cfg_addr;
    logic [CFG_DATA_W-1:0] cfg_wdata;
    rgb_t                  out_pixel;
    logic                  out_de;
    logic                  out_hs;
    logic                  out_second;

    // Model of both line memories, indexed like line_parity
    rgb_t        ref_buf [2][LINE_DEPTH];
    logic        wr_parity;
    // Both output copies of one source line
    rgb_t        cap_pix [2][LINE_DEPTH];
    logic        cap_second [2][LINE_DEPTH];
    logic [31:0] rng_state;
    int          err_cnt;
    int          tests_run;
    int          tests_failed;

    vdp_upscan_top UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .src_hs     (src_hs),
        .src_we     (src_we),
        .src_x      (src_x),
        .src_pixel  (src_pixel),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .out_pixel  (out_pixel),
        .out_de     (out_de),
        .out_hs     (out_hs),
        .out_second (out_second)
    );

    // 40 ns period
    always #20 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Next drive point, shortly after the rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic report_pixel(input int line, input int pos, input rgb_t got, input rgb_t want);
        err_cnt++;
        $display("FAIL %0t out_pixel[%0d][%0d] got %h expected %h",
                 $time, line, pos, got, want);
    endtask

    task automatic report_bit(input string sig, input logic got, input logic want);
        err_cnt++;
        $display("FAIL %0t %s got %b expected %b", $time, sig, got, want);
    endtask

    task automatic cfg_write(input cfg_addr_e addr, input logic [CFG_DATA_W-1:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        step();
        cfg_we    = 1'b0;
    endtask

    // Source line of random pixels, exactly 2 * H_TOTAL_OUT cycles
    task automatic send_line(input int n_pix);
        rgb_t pix;
        int   i;
        src_hs    = 1'b1;
        wr_parity = ~wr_parity;
        step();
        src_hs = 1'b0;
        for (i = 0; i < n_pix; i++) begin
            rng_state = xorshift32(rng_state);
            pix       = rgb_t'(rng_state[$bits(rgb_t)-1:0]);
            src_we    = 1'b1;
            src_x     = X_W'(i);
            src_pixel = pix;
            ref_buf[wr_parity][X_W'(i)] = pix;
            step();
        end
        src_we = 1'b0;
        repeat (2 * H_TOTAL_OUT - 1 - n_pix) step();
    endtask

    // Pixels and sync pulse of one output line from the rise of out_de
    task automatic capture_line(input logic line);
        int   cnt;
        int   k;
        logic hs_want;
        // Let a run in progress pass first
        cnt = 0;
        while (out_de === 1'b1 && cnt < WAIT_LIMIT) begin
            step();
            cnt++;
        end
        cnt = 0;
        while (out_de !== 1'b1 && cnt < WAIT_LIMIT) begin
            step();
            cnt++;
        end
        if (out_de !== 1'b1) begin
            err_cnt++;
            $display("Timeout: out_de did not rise within %0d cycles", WAIT_LIMIT);
        end else begin
            // Stops one short of the line end so the next rise is still ahead
            for (k = 0; k < H_TOTAL_OUT - 1; k++) begin
                hs_want = (k >= H_SYNC_START) && (k < H_SYNC_START + H_SYNC_LEN);
                if (out_hs !== hs_want) begin
                    report_bit("out_hs", out_hs, hs_want);
                end
                if (k < H_ACTIVE_OUT) begin
                    cap_pix[line][X_W'(k)]    = out_pixel;
                    cap_second[line][X_W'(k)] = out_second;
                end
                step();
            end
        end
    endtask

    task automatic line_with_capture(input int n_pix);
        fork
            send_line(n_pix);
            begin
                capture_line(1'b0);
                capture_line(1'b1);
            end
        join
    endtask

    // Both copies against the previous source line, i.e. the read buffer
    task automatic check_capture(input logic dim, input int ofs);
        rgb_t want;
        logic l;
        int   li;
        int   k;
        for (li = 0; li < 2; li++) begin
            l = 1'(li);
            for (k = 0; k < H_ACTIVE_OUT; k++) begin
                want = ref_buf[~wr_parity][X_W'(k + ofs)];
                // Dimmed repeat line, half of each channel
                if (dim && l) begin
                    want.r = want.r >> 1;
                    want.g = want.g >> 1;
                    want.b = want.b >> 1;
                end
                if (cap_pix[l][X_W'(k)] !== want) begin
                    report_pixel(li, k, cap_pix[l][X_W'(k)], want);
                end
                if (cap_second[l][X_W'(k)] !== l) begin
                    report_bit("out_second", cap_second[l][X_W'(k)], l);
                end
            end
        end
    endtask

    task automatic check_constant(input rgb_t want);
        int li;
        int k;
        for (li = 0; li < 2; li++) begin
            for (k = 0; k < H_ACTIVE_OUT; k++) begin
                if (cap_pix[1'(li)][X_W'(k)] !== want) begin
                    report_pixel(li, k, cap_pix[1'(li)][X_W'(k)], want);
                end
            end
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (err_cnt == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_cnt - err_before);
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        rgb_t border_col;
        int   start_err;
        int   diff;
        int   k;
        border_col = {6'h2a, 6'h15, 6'h0f};
        src_hs     = 1'b0;
        src_we     = 1'b0;
        src_x      = '0;
        src_pixel  = '0;
        cfg_we     = 1'b0;
        cfg_addr   = CFG_CTRL;
        cfg_wdata  = '0;
        arst_n     = 1'b0;
        wr_parity  = 1'b0;
        rng_state  = 32'd46;
        err_cnt    = 0;
        tests_run  = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Reset state, then black and coloured border while disabled
        start_err = err_cnt;
        step();
        if (out_de !== 1'b0) report_bit("out_de", out_de, 1'b0);
        if (out_hs !== 1'b0) report_bit("out_hs", out_hs, 1'b0);
        line_with_capture(H_ACTIVE_OUT);
        check_constant('0);
        cfg_write(CFG_BORDER, border_col);
        line_with_capture(H_ACTIVE_OUT);
        check_constant(border_col);
        end_test("reset_disabled", start_err);

        // Line A, then both copies of A drawn during line B
        start_err = err_cnt;
        cfg_write(CFG_CTRL, CFG_DATA_W'(2'b01));
        send_line(H_ACTIVE_OUT);
        line_with_capture(H_ACTIVE_OUT);
        check_capture(1'b0, 0);
        end_test("line_doubling", start_err);

        // A and B differ, and line C shows B
        start_err = err_cnt;
        diff = 0;
        for (k = 0; k < H_ACTIVE_OUT; k++) begin
            if (ref_buf[0][X_W'(k)] !== ref_buf[1][X_W'(k)]) diff++;
        end
        if (diff == 0) begin
            err_cnt++;
            $display("Lines A and B hold the same data, buffers cannot be told apart");
        end
        line_with_capture(H_ACTIVE_OUT);
        check_capture(1'b0, 0);
        end_test("double_buffer", start_err);

        // Second copy at half brightness
        start_err = err_cnt;
        cfg_write(CFG_CTRL, CFG_DATA_W'(2'b11));
        send_line(H_ACTIVE_OUT);
        line_with_capture(H_ACTIVE_OUT);
        check_capture(1'b1, 0);
        end_test("scanline", start_err);

        // Read starts 5 pixels into the stored line
        start_err = err_cnt;
        cfg_write(CFG_XOFS, CFG_DATA_W'(5));
        cfg_write(CFG_CTRL, CFG_DATA_W'(2'b01));
        send_line(H_ACTIVE_OUT + 5);
        line_with_capture(H_ACTIVE_OUT);
        check_capture(1'b0, 5);
        end_test("x_offset", start_err);

        // Assertion failures from the bound checker count as errors
        err_cnt = err_cnt + UUT.u_props.assert_fail_cnt;
        $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== test/vdp_upscan_props.sv ====
// Output timing checks for the upscan converter, bound to the top level
module vdp_upscan_props
    import vdp_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic out_de,
    input logic out_hs
);
    timeunit 1ns;
    timeprecision 1ps;

    // Cycles out_de has been high so far in the current run
    logic [X_W-1:0] de_run;
    // Failed assertions, read back by the testbench
    int             assert_fail_cnt = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de_run <= '0;
        end else if (out_de) begin
            de_run <= de_run + 1'b1;
        end else begin
            de_run <= '0;
        end
    end

    // --------------------
    // Output checks
    // --------------------

    // Active video and sync never overlap
    a_de_hs_apart: assert property (@(posedge clk) disable iff (!arst_n)
        !(out_de && out_hs))
        else begin
            assert_fail_cnt++;
            $error("out_de and out_hs high in the same cycle");
        end

    // A run that ends must have been exactly one visible line long
    a_de_run_len: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(out_de) |-> (de_run == X_W'(H_ACTIVE_OUT)))
        else begin
            assert_fail_cnt++;
            $error("out_de run ended after %0d cycles", de_run);
        end

    // Catches a run that grows past the line
    a_de_run_max: assert property (@(posedge clk) disable iff (!arst_n)
        out_de |-> (de_run < X_W'(H_ACTIVE_OUT)))
        else begin
            assert_fail_cnt++;
            $error("out_de run longer than a visible line");
        end

    // No video while reset is held
    a_de_reset: assert property (@(posedge clk) !arst_n |-> !out_de)
        else begin
            assert_fail_cnt++;
            $error("out_de high during reset");
        end

endmodule

// Attach to the top level
bind vdp_upscan_top vdp_upscan_props u_props (
    .clk    (clk),
    .arst_n (arst_n),
    .out_de (out_de),
    .out_hs (out_hs)
);

// ==== hw/vdp_upscan_top.sv ====
// Upscan converter top, line doubling of the source RGB stream
module vdp_upscan_top
    import vdp_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    // Source side
    input  logic                  src_hs,
    input  logic                  src_we,
    input  logic [X_W-1:0]        src_x,
    input  rgb_t                  src_pixel,
    // Register writes
    input  logic                  cfg_we,
    input  cfg_addr_e             cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_wdata,
    // Doubled output
    output rgb_t                  out_pixel,
    output logic                  out_de,
    output logic                  out_hs,
    output logic                  out_second
);

    cfg_t           cfg;
    logic           line_parity;
    logic [X_W-1:0] rd_x;
    scan_t          scan;
    rgb_t           rd_pixel;

    vdp_scan_cfg u_cfg (
        .clk       (clk),
        .arst_n    (arst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    vdp_upscan_timing u_timing (
        .clk         (clk),
        .arst_n      (arst_n),
        .src_hs      (src_hs),
        .x_offset    (cfg.x_offset),
        .line_parity (line_parity),
        .rd_x        (rd_x),
        .scan        (scan)
    );

    // Source writes one buffer, output reads the other
    vdp_doublebuf u_dbuf (
        .clk         (clk),
        .line_parity (line_parity),
        .wr_en       (src_we),
        .wr_x        (src_x),
        .wr_pixel    (src_pixel),
        .rd_x        (rd_x),
        .rd_pixel    (rd_pixel)
    );

    vdp_pixel_out u_out (
        .clk        (clk),
        .arst_n     (arst_n),
        .scan       (scan),
        .rd_pixel   (rd_pixel),
        .enable     (cfg.enable),
        .scanline   (cfg.scanline),
        .border     (cfg.border),
        .out_pixel  (out_pixel),
        .out_de     (out_de),
        .out_hs     (out_hs),
        .out_second (out_second)
    );

endmodule

// ==== hw/vdp_pixel_out.sv ====
// Output stage with border, blanking and scanline dimming
module vdp_pixel_out
    import vdp_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  scan_t scan,
    input  rgb_t  rd_pixel,
    input  logic  enable,
    input  logic  scanline,
    input  rgb_t  border,
    output rgb_t  out_pixel,
    output logic  out_de,
    output logic  out_hs,
    output logic  out_second
);

    rgb_t pix_next;

    // --------------------
    // Pixel select
    // --------------------

    always_comb begin
        if (!scan.de) begin
            // Blanking
            pix_next = '0;
        end else if (!enable) begin
            pix_next = border;
        end else if (scanline && scan.second) begin
            // Half brightness on the repeated line
            pix_next.r = rd_pixel.r >> 1;
            pix_next.g = rd_pixel.g >> 1;
            pix_next.b = rd_pixel.b >> 1;
        end else begin
            pix_next = rd_pixel;
        end
    end

    // Pixel register
    always_ff @(posedge clk) begin
        out_pixel <= pix_next;
    end

    // Flags stay aligned with the pixel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_de     <= 1'b0;
            out_hs     <= 1'b0;
            out_second <= 1'b0;
        end else begin
            out_de     <= scan.de;
            out_hs     <= scan.hs;
            out_second <= scan.second;
        end
    end

endmodule

// ==== hw/vdp_scan_cfg.sv ====
// Configuration registers for enable, scanline dimming, read offset and border
module vdp_scan_cfg
    import vdp_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cfg_we,
    input  cfg_addr_e             cfg_addr,
    input  logic [CFG_DATA_W-1:0] cfg_wdata,
    output cfg_t                  cfg
);

    // --------------------
    // Register writes
    // --------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Disabled, black border
            cfg <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_CTRL: begin
                    // Bit 0 enable, bit 1 scanline
                    cfg.enable   <= cfg_wdata[0];
                    cfg.scanline <= cfg_wdata[1];
                end
                CFG_XOFS: begin
                    cfg.x_offset <= cfg_wdata[X_W-1:0];
                end
                CFG_BORDER: begin
                    // Packed r, g, b from the top bit down
                    cfg.border <= rgb_t'(cfg_wdata);
                end
                default: begin
                    // Unmapped code, nothing changes
                    cfg <= cfg;
                end
            endcase
        end
    end

endmodule

// ==== hw/vdp_upscan_timing.sv ====
// Output line timing, draws each source line twice at double line rate
module vdp_upscan_timing
    import vdp_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           src_hs,
    input  logic [X_W-1:0] x_offset,
    output logic           line_parity,
    output logic [X_W-1:0] rd_x,
    output scan_t          scan
);

    // Output horizontal counter
    logic [X_W-1:0] h_cnt;
    // Drawing the repeated copy of the line
    logic           second;
    // Both copies drawn, waiting for the next source line
    logic           idle;
    // Flags aligned with rd_x
    scan_t          scan_req;
    logic           last_pix;

    assign last_pix = (h_cnt == X_W'(H_TOTAL_OUT - 1));

    // --------------------
    // Counter and line state
    // --------------------

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt       <= X_W'(H_TOTAL_OUT - 1);
            second      <= 1'b0;
            idle        <= 1'b1;
            line_parity <= 1'b0;
        end else if (src_hs) begin
            // New source line restarts everything
            h_cnt       <= '0;
            second      <= 1'b0;
            idle        <= 1'b0;
            line_parity <= ~line_parity;
        end else if (!idle) begin
            if (last_pix) begin
                if (second) begin
                    // No third copy, hold at end of line
                    idle <= 1'b1;
                end else begin
                    h_cnt  <= '0;
                    second <= 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // --------------------
    // Read request
    // --------------------

    // Offset read position, wraps at the memory size
    always_ff @(posedge clk) begin
        rd_x <= h_cnt + x_offset;
    end

    // Active area and sync window
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_req <= '0;
        end else begin
            scan_req.de     <= (h_cnt < X_W'(H_ACTIVE_OUT));
            scan_req.hs     <= (h_cnt >= X_W'(H_SYNC_START)) &&
                               (h_cnt < X_W'(H_SYNC_START + H_SYNC_LEN));
            scan_req.second <= second;
        end
    end

    // One more stage to meet the RAM read data
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan <= '0;
        end else begin
            scan <= scan_req;
        end
    end

endmodule

// ==== hw/vdp_doublebuf.sv ====
// Double-buffered line memory, one buffer written while the other is read
module vdp_doublebuf
    import vdp_pkg::*;
(
    input  logic           clk,
    input  logic           line_parity,
    input  logic           wr_en,
    input  logic [X_W-1:0] wr_x,
    input  rgb_t           wr_pixel,
    input  logic [X_W-1:0] rd_x,
    output rgb_t           rd_pixel
);

    logic           we_even;
    logic           we_odd;
    logic [X_W-1:0] addr_even;
    logic [X_W-1:0] addr_odd;
    rgb_t           q_even;
    rgb_t           q_odd;
    // Parity seen by the RAM read one cycle ago
    logic           rd_parity_q;

    // --------------------
    // Steering
    // --------------------

    // Write side follows line_parity
    assign we_even = wr_en & ~line_parity;
    assign we_odd  = wr_en & line_parity;

    // The other buffer serves the read address
    assign addr_even = line_parity ? rd_x : wr_x;
    assign addr_odd  = line_parity ? wr_x : rd_x;

    // --------------------
    // Buffers
    // --------------------

    vdp_linebuf u_buf_even (
        .clk   (clk),
        .we    (we_even),
        .addr  (addr_even),
        .wdata (wr_pixel),
        .rdata (q_even)
    );

    vdp_linebuf u_buf_odd (
        .clk   (clk),
        .we    (we_odd),
        .addr  (addr_odd),
        .wdata (wr_pixel),
        .rdata (q_odd)
    );

    // Match the read data with the parity that addressed it
    always_ff @(posedge clk) begin
        rd_parity_q <= line_parity;
    end

    // Odd parity means the even buffer was being read
    assign rd_pixel = rd_parity_q ? q_even : q_odd;

endmodule

// ==== hw/vdp_linebuf.sv ====
// Line memory holding one RGB word per x position, registered read
module vdp_linebuf
    import vdp_pkg::*;
(
    input  logic           clk,
    input  logic           we,
    input  logic [X_W-1:0] addr,
    input  rgb_t           wdata,
    output rgb_t           rdata
);

    // One source line of pixels
    rgb_t mem [LINE_DEPTH];

    // Single port, read and write share the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        // Old contents come out on a same-address write
        rdata <= mem[addr];
    end

endmodule

// ==== hw/vdp_pkg.sv ====
// Upscan converter shared widths, line timing and packed types
package vdp_pkg;

    // --------------------
    // Widths
    // --------------------

    // X position, also the line memory address
    localparam int X_W        = 10;
    // Words in one line memory
    localparam int LINE_DEPTH = 1024;
    // Bits per colour channel
    localparam int COLOR_W    = 6;
    // Register write data, wide enough for a full colour
    localparam int CFG_DATA_W = 3 * COLOR_W;

    // --------------------
    // Output line timing
    // --------------------

    // Visible pixels per output line
    localparam int H_ACTIVE_OUT = 256;
    // Clocks per output line, half a source line
    localparam int H_TOTAL_OUT  = 320;
    // Sync pulse placement
    localparam int H_SYNC_START = 272;
    localparam int H_SYNC_LEN   = 32;

    // --------------------
    // Types
    // --------------------

    // One pixel, 18 bits
    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } rgb_t;

    // Output stage configuration, 30 bits
    typedef struct packed {
        logic           enable;
        logic           scanline;
        logic [X_W-1:0] x_offset;
        rgb_t           border;
    } cfg_t;

    // Output position flags that travel with the read
    typedef struct packed {
        logic de;
        logic hs;
        logic second;
    } scan_t;

    // Register map
    typedef enum logic [1:0] {
        CFG_CTRL   = 2'd0,
        CFG_XOFS   = 2'd1,
        CFG_BORDER = 2'd2
    } cfg_addr_e;

endpackage
